// ==== Makefile ====
TOP = tb_icache
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== compile.f ====
+incdir+src
src/icache_pkg.sv
src/line_sram.sv
src/icache_tags.sv
src/icache_ctrl.sv
src/icache_top.sv
testbench/tb_mem.sv
testbench/tb_icache.sv

// ==== src/icache_ctrl.sv ====
`include "icache_defs.svh"

module icache_ctrl (
	input logic clk,
	input logic rst,

	input logic fetch_valid,
	input icache_pkg::addr_t fetch_addr,
	output logic fetch_ready,
	input logic flush,
	input logic ifid_ready,
	output icache_pkg::word_t inst,
	output logic inst_valid,

	output icache_pkg::index_t tag_index,
	output icache_pkg::tag_t tag_tag,
	input icache_pkg::way_t hit,
	input icache_pkg::way_t victim,
	output logic fill,

	output icache_pkg::way_t sram_en,
	output logic sram_we,
	output icache_pkg::index_t sram_index,
	output icache_pkg::line_t sram_wdata,
	input icache_pkg::line_t sram_rdata0,
	input icache_pkg::line_t sram_rdata1,
	input icache_pkg::line_t sram_rdata2,
	input icache_pkg::line_t sram_rdata3,

	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output icache_pkg::addr_t wb_adr,
	input icache_pkg::word_t wb_dat_i,
	input logic wb_ack
);

	localparam int IDX_LSB = $clog2(`ICACHE_LINE_BYTES);
	localparam int TAG_LSB = IDX_LSB + $bits(icache_pkg::index_t);
	localparam int WORD_W = $bits(icache_pkg::word_t);

	icache_pkg::ctrl_state_t state;
	icache_pkg::ctrl_state_t state_next;
	icache_pkg::addr_t addr_q;
	icache_pkg::addr_t look_addr;
	icache_pkg::offset_t beat;
	icache_pkg::offset_t word_sel;
	icache_pkg::way_t rd_way;
	icache_pkg::line_t line_buf;
	icache_pkg::line_t way_rdata;
	icache_pkg::word_t sram_word;
	icache_pkg::word_t inst_q;
	logic hold_q;
	logic drop_q;
	logic accept;
	logic consume;
	logic last_beat;

	assign fetch_ready = (state == icache_pkg::IDLE) || ((state == icache_pkg::RESULT) && consume);
	assign inst_valid = (state == icache_pkg::RESULT) && !flush;
	assign consume = inst_valid && ifid_ready;
	assign accept = fetch_valid && fetch_ready;

	// Look up the incoming request, else the one in flight.
	assign look_addr = fetch_ready ? fetch_addr : addr_q;
	assign tag_index = look_addr[TAG_LSB-1:IDX_LSB];
	assign tag_tag = look_addr[`ICACHE_ADDR_W-1:TAG_LSB];

	assign sram_index = tag_index;
	assign sram_we = (state == icache_pkg::WRITE);
	assign sram_wdata = line_buf;
	assign sram_en = (state == icache_pkg::WRITE) ? victim : (accept ? hit : '0);
	assign fill = (state == icache_pkg::WRITE);

	assign last_beat = (beat == icache_pkg::offset_t'(`ICACHE_BEATS - 1));
	assign wb_cyc = (state == icache_pkg::REFILL);
	assign wb_stb = (state == icache_pkg::REFILL);
	assign wb_we = 1'b0;
	assign wb_adr = {addr_q[`ICACHE_ADDR_W-1:IDX_LSB], beat, 2'b00};

	always_comb begin
		case (rd_way)
			4'b0001: way_rdata = sram_rdata0;
			4'b0010: way_rdata = sram_rdata1;
			4'b0100: way_rdata = sram_rdata2;
			4'b1000: way_rdata = sram_rdata3;
			default: way_rdata = '0;
		endcase
	end

	assign word_sel = addr_q[IDX_LSB-1:2];
	assign sram_word = way_rdata[word_sel*WORD_W +: WORD_W];
	assign inst = hold_q ? inst_q : sram_word;

	always_comb begin
		state_next = state;
		if (accept) begin
			state_next = (|hit) ? icache_pkg::RESULT : icache_pkg::LOOKUP;
		end else begin
			case (state)
				icache_pkg::LOOKUP: state_next = icache_pkg::REFILL;
				icache_pkg::REFILL: begin
					if (wb_ack && last_beat) begin
						state_next = icache_pkg::WRITE;
					end
				end
				// Line stays cached even when the result is dropped.
				icache_pkg::WRITE: begin
					state_next = (drop_q || flush) ? icache_pkg::IDLE : icache_pkg::RESULT;
				end
				icache_pkg::RESULT: begin
					if (flush || consume) begin
						state_next = icache_pkg::IDLE;
					end
				end
				default: state_next = icache_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= icache_pkg::IDLE;
			beat <= '0;
			rd_way <= '0;
			hold_q <= 1'b0;
			drop_q <= 1'b0;
		end else begin
			state <= state_next;
			if (accept) begin
				drop_q <= 1'b0;
			end else if (flush) begin
				drop_q <= 1'b1;
			end
			if (accept) begin
				rd_way <= hit;
			end else if (state == icache_pkg::WRITE) begin
				rd_way <= victim;
			end
			if (state == icache_pkg::LOOKUP) begin
				beat <= '0;
			end else if (wb_stb && wb_ack) begin
				beat <= beat + 1'b1;
			end
			hold_q <= inst_valid && !ifid_ready;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q <= fetch_addr;
		end
		if (wb_stb && wb_ack) begin
			line_buf[beat*WORD_W +: WORD_W] <= wb_dat_i;
		end
		// Capture on the first stalled cycle.
		if (inst_valid && !hold_q) begin
			inst_q <= sram_word;
		end
	end

	a_stb_in_cyc: assert property (
		@(posedge clk) disable iff (rst)
		wb_stb |-> wb_cyc
	);

	a_no_result_in_refill: assert property (
		@(posedge clk) disable iff (rst)
		(state == icache_pkg::REFILL) |-> !inst_valid
	);

	// Beat request held until acked.
	a_beat_stable: assert property (
		@(posedge clk) disable iff (rst)
		(wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr))
	);

endmodule

// ==== src/icache_defs.svh ====
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Physical address width in bits.
`define ICACHE_ADDR_W 32

// Number of sets per way.
`define ICACHE_SETS 64

// Associativity.
`define ICACHE_WAYS 4

// Line size in bytes.
`define ICACHE_LINE_BYTES 16

// Bus beats per line refill.
`define ICACHE_BEATS 4

`endif

// ==== src/icache_pkg.sv ====
`include "icache_defs.svh"

package icache_pkg;

	typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [`ICACHE_LINE_BYTES*8-1:0] line_t;

	// Address split into tag, set index, word offset and byte offset.
	typedef logic [$clog2(`ICACHE_SETS)-1:0] index_t;
	typedef logic [$clog2(`ICACHE_BEATS)-1:0] offset_t;
	typedef logic [`ICACHE_ADDR_W-$clog2(`ICACHE_SETS)-$clog2(`ICACHE_LINE_BYTES)-1:0] tag_t;

	// One-hot way select.
	typedef logic [`ICACHE_WAYS-1:0] way_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		REFILL,
		WRITE,
		RESULT
	} ctrl_state_t;

endpackage

// ==== src/icache_tags.sv ====
`include "icache_defs.svh"

module icache_tags (
	input logic clk,
	input logic rst,
	input icache_pkg::index_t index,
	input icache_pkg::tag_t tag,
	input logic fill,
	output icache_pkg::way_t hit,
	output icache_pkg::way_t victim
);

	icache_pkg::tag_t tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
	logic [`ICACHE_SETS-1:0] valid_bits [`ICACHE_WAYS];
	icache_pkg::way_t victim_ptr;

	assign victim = victim_ptr;

	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			hit[w] = valid_bits[w][index] && (tag_mem[w][index] == tag);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				valid_bits[w] <= '0;
			end
			victim_ptr <= icache_pkg::way_t'(1);
		end else if (fill) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (victim_ptr[w]) begin
					valid_bits[w][index] <= 1'b1;
				end
			end
			// Round robin replacement.
			victim_ptr <= {victim_ptr[`ICACHE_WAYS-2:0], victim_ptr[`ICACHE_WAYS-1]};
		end
	end

	always_ff @(posedge clk) begin
		if (fill) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (victim_ptr[w]) begin
					tag_mem[w][index] <= tag;
				end
			end
		end
	end

	// A line lives in at most one way.
	a_hit_onehot: assert property (
		@(posedge clk) disable iff (rst)
		$onehot0(hit)
	);

	// Refill only happens for a line that missed.
	a_fill_on_miss: assert property (
		@(posedge clk) disable iff (rst)
		fill |-> (hit == '0)
	);

endmodule

// ==== src/icache_top.sv ====
`include "icache_defs.svh"

module icache_top (
	input logic clk,
	input logic rst,

	input logic fetch_valid,
	input icache_pkg::addr_t fetch_addr,
	output logic fetch_ready,
	input logic flush,
	input logic ifid_ready,
	output icache_pkg::word_t inst,
	output logic inst_valid,

	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output icache_pkg::addr_t wb_adr,
	input icache_pkg::word_t wb_dat_i,
	input logic wb_ack
);

	icache_pkg::index_t tag_index;
	icache_pkg::tag_t tag_tag;
	icache_pkg::way_t hit;
	icache_pkg::way_t victim;
	logic fill;
	icache_pkg::way_t sram_en;
	logic sram_we;
	icache_pkg::index_t sram_index;
	icache_pkg::line_t sram_wdata;
	icache_pkg::line_t sram_rdata [`ICACHE_WAYS];

	icache_ctrl ctrl_i (
		.clk(clk),
		.rst(rst),
		.fetch_valid(fetch_valid),
		.fetch_addr(fetch_addr),
		.fetch_ready(fetch_ready),
		.flush(flush),
		.ifid_ready(ifid_ready),
		.inst(inst),
		.inst_valid(inst_valid),
		.tag_index(tag_index),
		.tag_tag(tag_tag),
		.hit(hit),
		.victim(victim),
		.fill(fill),
		.sram_en(sram_en),
		.sram_we(sram_we),
		.sram_index(sram_index),
		.sram_wdata(sram_wdata),
		.sram_rdata0(sram_rdata[0]),
		.sram_rdata1(sram_rdata[1]),
		.sram_rdata2(sram_rdata[2]),
		.sram_rdata3(sram_rdata[3]),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack)
	);

	icache_tags tags_i (
		.clk(clk),
		.rst(rst),
		.index(tag_index),
		.tag(tag_tag),
		.fill(fill),
		.hit(hit),
		.victim(victim)
	);

	for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
		line_sram sram_i (
			.clk(clk),
			.en(sram_en[w]),
			.we(sram_we),
			.index(sram_index),
			.wdata(sram_wdata),
			.rdata(sram_rdata[w])
		);
	end

endmodule

// ==== src/line_sram.sv ====
`include "icache_defs.svh"

module line_sram (
	input logic clk,
	input logic en,
	input logic we,
	input icache_pkg::index_t index,
	input icache_pkg::line_t wdata,
	output icache_pkg::line_t rdata
);

	icache_pkg::line_t mem [`ICACHE_SETS];

	// Write-first so that a written line also shows up on the output.
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[index] <= wdata;
				rdata <= wdata;
			end else begin
				rdata <= mem[index];
			end
		end
	end

endmodule

// ==== testbench/tb_icache.sv ====
module tb_icache;

	localparam int WAIT_LIMIT = 100;

	logic clk;
	logic rst;
	logic fetch_valid;
	logic [31:0] fetch_addr;
	logic fetch_ready;
	logic flush;
	logic ifid_ready;
	logic [31:0] inst;
	logic inst_valid;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat;
	logic wb_ack;

	logic [31:0] row_addr [$];
	int row_stall [$];
	bit row_flush [$];
	bit row_refill [$];
	bit table_loaded = 1'b0;

	int cycle = 0;
	int accept_count = 0;
	int accept_cyc = 0;
	int last_ack_cyc = 0;
	int acks = 0;
	logic [31:0] req_addr = '0;
	int error_count = 0;
	int rows_failed = 0;

	icache_top icache_top_i (
		.clk(clk),
		.rst(rst),
		.fetch_valid(fetch_valid),
		.fetch_addr(fetch_addr),
		.fetch_ready(fetch_ready),
		.flush(flush),
		.ifid_ready(ifid_ready),
		.inst(inst),
		.inst_valid(inst_valid),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_i(wb_dat),
		.wb_ack(wb_ack)
	);

	tb_mem mem_i (
		.clk(clk),
		.rst(rst),
		.cyc(wb_cyc),
		.stb(wb_stb),
		.adr(wb_adr),
		.dat(wb_dat),
		.ack(wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_equal(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic add_row(input logic [31:0] addr, input int stall, input bit flush_row,
			input bit refill);
		row_addr.push_back(addr);
		row_stall.push_back(stall);
		row_flush.push_back(flush_row);
		row_refill.push_back(refill);
	endtask

	// Handshake and bus monitor checking that beats walk the line in order.
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (!rst) begin
			if (fetch_valid && fetch_ready) begin
				accept_count <= accept_count + 1;
				accept_cyc <= cycle;
				req_addr <= fetch_addr;
				acks <= 0;
			end
			if (wb_cyc && wb_stb && wb_ack) begin
				check_equal("wb_adr", {req_addr[31:4], 4'h0} + 32'(acks * 4), wb_adr);
				check_equal("wb_we", 32'h0, 32'(wb_we));
				acks <= acks + 1;
				last_ack_cyc <= cycle;
			end
		end
	end

	task automatic run_row(input int i);
		int errors_before;
		int accepts_before;
		int waited;
		errors_before = error_count;
		accepts_before = accept_count;
		fetch_valid = 1'b1;
		fetch_addr = row_addr[i];
		ifid_ready = (row_stall[i] == 0);
		waited = 0;
		while (accept_count == accepts_before && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		fetch_valid = 1'b0;
		if (accept_count == accepts_before) begin
			$display("row %0d: the cache never accepted the request", i);
			error_count++;
		end else if (row_flush[i]) begin
			// Kill the result while the miss is still in flight.
			flush = 1'b1;
			waited = 0;
			do begin
				@(negedge clk);
				flush = 1'b0;
				check_equal("inst_valid", 32'h0, 32'(inst_valid));
				waited++;
			end while (!fetch_ready && waited < WAIT_LIMIT);
			if (!fetch_ready) begin
				$display("row %0d: the cache did not return to idle after the flush", i);
				error_count++;
			end
		end else begin
			waited = 0;
			while (!inst_valid && waited < WAIT_LIMIT) begin
				@(negedge clk);
				waited++;
			end
			if (!inst_valid) begin
				$display("row %0d: no instruction came back", i);
				error_count++;
			end else begin
				if (row_refill[i]) begin
					check_equal("refill_latency", 32'd2, cycle - last_ack_cyc);
				end else begin
					check_equal("hit_latency", 32'd1, cycle - accept_cyc);
				end
				check_equal("inst", ~row_addr[i], inst);
				repeat (row_stall[i]) begin
					@(negedge clk);
					check_equal("inst_valid", 32'h1, 32'(inst_valid));
					check_equal("inst", ~row_addr[i], inst);
				end
				ifid_ready = 1'b1;
				@(negedge clk);
				check_equal("inst_valid", 32'h0, 32'(inst_valid));
			end
		end
		check_equal("wb_acks", row_refill[i] ? 32'd4 : 32'd0, acks);
		if (error_count != errors_before) begin
			rows_failed++;
		end
		$display("row %0d addr %h: %s", i, row_addr[i],
			(error_count == errors_before) ? "ok" : "mismatch");
	endtask

	initial begin
		rst = 1'b1;
		fetch_valid = 1'b0;
		fetch_addr = '0;
		flush = 1'b0;
		ifid_ready = 1'b1;
		// Address, cycles with ifid_ready low, flush, refill expected.
		add_row(32'h0000_1000, 0, 1'b0, 1'b1);
		add_row(32'h0000_1000, 0, 1'b0, 1'b0);
		add_row(32'h0000_1004, 0, 1'b0, 1'b0);
		add_row(32'h0000_1008, 0, 1'b0, 1'b0);
		add_row(32'h0000_100c, 0, 1'b0, 1'b0);
		// Five tags in set 5 overflow the four ways.
		add_row(32'h0000_2050, 0, 1'b0, 1'b1);
		add_row(32'h0000_4054, 0, 1'b0, 1'b1);
		add_row(32'h0000_6058, 0, 1'b0, 1'b1);
		add_row(32'h0000_805c, 0, 1'b0, 1'b1);
		add_row(32'h0000_a050, 0, 1'b0, 1'b1);
		add_row(32'h0000_2050, 0, 1'b0, 1'b1);
		add_row(32'h0000_a050, 0, 1'b0, 1'b0);
		add_row(32'h0000_1008, 4, 1'b0, 1'b0);
		add_row(32'h0000_3000, 3, 1'b0, 1'b1);
		add_row(32'h0000_5100, 0, 1'b1, 1'b1);
		add_row(32'h0000_5100, 0, 1'b0, 1'b0);
		add_row(32'h0000_510c, 0, 1'b0, 1'b0);
		table_loaded = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_equal("fetch_ready", 32'h1, 32'(fetch_ready));
		check_equal("inst_valid", 32'h0, 32'(inst_valid));
		check_equal("wb_cyc", 32'h0, 32'(wb_cyc));
		check_equal("wb_stb", 32'h0, 32'(wb_stb));
		$display("reset state: %s", (error_count == 0) ? "ok" : "mismatch");
		for (int i = 0; i < row_addr.size(); i++) begin
			run_row(i);
		end
		$display("rows %0d, failed rows %0d, failed checks %0d", row_addr.size(), rows_failed,
			error_count);
		if (error_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		wait (table_loaded);
		repeat (row_addr.size() * 200) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", row_addr.size() * 200);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== testbench/tb_mem.sv ====
module tb_mem (
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic [31:0] adr,
	output logic [31:0] dat,
	output logic ack
);

	int seed = 34628;
	int remain;

	// Every word reads back as the complement of its byte address.
	assign dat = ~adr;

	// Ack comes once the drawn wait for the current beat has run out.
	assign ack = cyc && stb && (remain == 0);

	// The wait for the next beat is drawn as soon as a beat is acked.
	always @(posedge clk) begin
		if (rst) begin
			remain <= int'($unsigned($random(seed)) % 4);
		end else if (cyc && stb) begin
			if (remain == 0) begin
				remain <= int'($unsigned($random(seed)) % 4);
			end else begin
				remain <= remain - 1;
			end
		end
	end

endmodule
